// ==== bench/mem_tests.txt ====
// each line holds kind op addr wdata expected_rdata in hex
// kind 1 is a load, 2 a store and 3 an atomic access
2 2 100 11223344 00000000
2 1 102 0000aabb 00000000
2 0 101 000000cc 00000000
1 2 100 00000000 aabbcc44
2 0 107 0000005a 00000000
1 2 104 00000000 5a000000
// sub-word loads
1 8 103 00000000 ffffffaa
1 0 103 00000000 000000aa
1 8 100 00000000 00000044
1 0 101 00000000 000000cc
1 9 102 00000000 ffffaabb
1 1 102 00000000 0000aabb
1 9 100 00000000 ffffcc44
1 8 107 00000000 0000005a
// lr and sc
2 2 200 00000007 00000000
3 0 200 00000000 00000007
3 1 200 00000009 00000000
1 2 200 00000000 00000009
3 1 200 12345678 00000001
1 2 200 00000000 00000009
3 0 200 00000000 00000009
3 1 204 deadbeef 00000001
1 2 204 00000000 00000000
// amo ops
2 2 300 0000000a 00000000
3 3 300 00000005 0000000a
3 4 300 000000ff 0000000f
3 5 300 00000030 000000f0
3 6 300 00000101 00000030
3 2 300 80000000 00000131
3 7 300 00000001 80000000
3 9 300 00000001 80000000
3 8 300 fffffffe 00000001
3 a 300 fffffffe 00000001
3 8 300 00000003 fffffffe
1 2 300 00000000 00000003
// held store then amo add
2 2 304 00000010 00000000
3 3 304 00000001 00000010
1 2 304 00000000 00000011

// ==== bench/tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem;

    localparam int max_tests = 64;
    localparam int fields    = 5;  // kind, op, addr, wdata, expected rdata

    logic                         clk;
    logic                         rst_n;
    logic                         mem_valid;
    logic [mem_pkg::iid_w-1:0]    mem_inst_id;
    mem_pkg::mem_sel_t            mem_sel;
    mem_pkg::mem_op_u             mem_op;
    logic [mem_pkg::addr_w-1:0]   mem_addr;
    logic [mem_pkg::xlen-1:0]     mem_wdata;
    logic                         wb_valid;
    logic [mem_pkg::iid_w-1:0]    wb_inst_id;
    logic [mem_pkg::xlen-1:0]     wb_rdata;
    logic                         stall;

    logic [31:0] tv [max_tests*fields];
    int          num_tests;
    int          limit;
    int          cycle_cnt;
    int          errors;
    int          seed;

    mem_subsystem u_mem_subsystem (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_valid   (mem_valid),
        .mem_inst_id (mem_inst_id),
        .mem_sel     (mem_sel),
        .mem_op      (mem_op),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .wb_valid    (wb_valid),
        .wb_inst_id  (wb_inst_id),
        .wb_rdata    (wb_rdata),
        .stall       (stall)
    );

    always #10 clk = ~clk;

    task automatic finish_run();
        $display("errors: %0d over %0d tests", errors, num_tests);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    endtask

    // one access from the table, then the same id held for a few cycles
    task automatic run_access(input int idx);
        logic [31:0] exp_rdata;
        int          hold;

        exp_rdata = tv[idx*fields+4];
        @(posedge clk);
        #1;
        mem_valid   = 1'b1;
        mem_inst_id = mem_inst_id + 1'b1;  // fresh id
        mem_sel     = mem_pkg::mem_sel_t'(tv[idx*fields][1:0]);
        mem_op      = tv[idx*fields+1][3:0];
        mem_addr    = tv[idx*fields+2][mem_pkg::addr_w-1:0];
        mem_wdata   = tv[idx*fields+3];

        @(negedge clk);
        while (stall)
            @(negedge clk);

        if (wb_rdata !== exp_rdata) begin
            $display("ERR t=%0t test %0d: wb_rdata expected %08h, got %08h",
                     $time, idx, exp_rdata, wb_rdata);
            errors++;
        end
        if (wb_inst_id !== mem_inst_id) begin
            $display("ERR t=%0t test %0d: wb_inst_id expected %0h, got %0h",
                     $time, idx, mem_inst_id, wb_inst_id);
            errors++;
        end
        if (wb_valid !== 1'b1) begin
            $display("ERR t=%0t test %0d: wb_valid expected 1, got %b",
                     $time, idx, wb_valid);
            errors++;
        end

        hold = 1 + ($random(seed) & 3);
        repeat (hold) begin
            @(negedge clk);
            if (stall !== 1'b0) begin
                $display("ERR t=%0t test %0d: stall expected 0 while id is held, got %b",
                         $time, idx, stall);
                errors++;
            end
        end
    endtask

    initial begin
        int i;

        clk         = 1'b0;
        rst_n       = 1'b0;
        mem_valid   = 1'b0;
        mem_inst_id = '0;
        mem_sel     = mem_pkg::sel_none;
        mem_op      = '0;
        mem_addr    = '0;
        mem_wdata   = '0;
        errors      = 0;
        num_tests   = 0;
        seed        = 76943;

        for (i = 0; i < max_tests*fields; i++)
            tv[i] = 32'hffff_ffff;  // end marker
        $readmemh("bench/mem_tests.txt", tv);
        while (num_tests < max_tests && tv[num_tests*fields] !== 32'hffff_ffff)
            num_tests++;

        if (num_tests == 0) begin
            $display("no tests could be read from bench/mem_tests.txt");
            errors++;
            finish_run();
        end else begin
            limit = 20 * num_tests + 50;
            repeat (3) @(posedge clk);
            #1;
            rst_n = 1'b1;

            for (i = 0; i < num_tests; i++)
                run_access(i);
            finish_run();
        end
    end

    // watchdog
    initial begin
        cycle_cnt = 0;
        wait (limit > 0);
        while (cycle_cnt < limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("run timed out after %0d cycles with accesses still pending", cycle_cnt);
        errors++;
        finish_run();
    end

endmodule

// ==== compile.f ====
src/mem_pkg.sv
src/amo_alu.sv
src/memory_stage.sv
src/data_ram.sv
src/mem_subsystem.sv
bench/tb_mem_subsystem.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
    --top-module tb_mem_subsystem -Mdir obj_dir -o sim

./obj_dir/sim | tee sim.log

grep -q "Done: no errors" sim.log

// ==== src/amo_alu.sv ====
`timescale 1ns/1ps

module amo_alu (
    input  mem_pkg::amo_sel_t         amo_sel,
    input  logic [mem_pkg::xlen-1:0]  old_data,
    input  logic [mem_pkg::xlen-1:0]  operand,
    output logic [mem_pkg::xlen-1:0]  new_data
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(old_data) < $signed(operand);
    assign lt_unsigned = old_data < operand;

    always_comb begin
        case (amo_sel)
            mem_pkg::amo_add:  new_data = old_data + operand;
            mem_pkg::amo_xor:  new_data = old_data ^ operand;
            mem_pkg::amo_and:  new_data = old_data & operand;
            mem_pkg::amo_or:   new_data = old_data | operand;
            mem_pkg::amo_min:  new_data = lt_signed ? old_data : operand;
            mem_pkg::amo_max:  new_data = lt_signed ? operand : old_data;
            mem_pkg::amo_minu: new_data = lt_unsigned ? old_data : operand;
            mem_pkg::amo_maxu: new_data = lt_unsigned ? operand : old_data;
            // swap and sc write rs2 unchanged
            default:           new_data = operand;
        endcase
    end

endmodule

// ==== src/data_ram.sv ====
`timescale 1ns/1ps

module data_ram (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         dreq_valid,
    input  logic                         dreq_wen,
    input  logic [mem_pkg::addr_w-1:0]   dreq_addr,
    input  logic [mem_pkg::xlen-1:0]     dreq_wdata,
    input  mem_pkg::mem_size_t           dreq_size,
    output logic                         dreq_ready,

    output logic                         dresp_valid,
    output logic [mem_pkg::xlen-1:0]     dresp_rdata
);

    logic [mem_pkg::xlen-1:0]        mem [mem_pkg::ram_words];
    logic [mem_pkg::lat_cnt_w-1:0]   rd_cnt;
    logic                            accept;
    logic [mem_pkg::addr_w-3:0]      widx;
    logic [4:0]                      lane_shift;
    logic [3:0]                      be;
    logic [mem_pkg::xlen-1:0]        wdata_sh;

    assign accept     = dreq_valid && dreq_ready;
    assign widx       = dreq_addr[mem_pkg::addr_w-1:2];
    assign lane_shift = {dreq_addr[1:0], 3'b000};
    assign wdata_sh   = dreq_wdata << lane_shift;

    always_comb begin
        case (dreq_size)
            mem_pkg::size_b: be = 4'b0001 << dreq_addr[1:0];
            mem_pkg::size_h: be = 4'b0011 << dreq_addr[1:0];
            default:         be = 4'b1111;
        endcase
    end

    assign dreq_ready  = rd_cnt == '0;
    assign dresp_valid = rd_cnt == 1;  // last cycle of the countdown

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_cnt <= '0;
        end else if (accept && !dreq_wen) begin
            rd_cnt <= mem_pkg::lat_cnt_w'(mem_pkg::ram_latency);
        end else if (rd_cnt != '0) begin
            rd_cnt <= rd_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mem_pkg::ram_words; i++)
                mem[i] <= '0;
        end else if (accept && dreq_wen) begin
            for (int b = 0; b < 4; b++)
                if (be[b])
                    mem[widx][8*b +: 8] <= wdata_sh[8*b +: 8];
        end
    end

    // read data lands at byte 0
    always_ff @(posedge clk) begin
        if (accept && !dreq_wen)
            dresp_rdata <= mem[widx] >> lane_shift;
    end

    // nothing taken until the read has been answered
    a_no_accept_busy: assert property (@(posedge clk) disable iff (!rst_n)
        accept && !dreq_wen |=>
            !accept ##(mem_pkg::ram_latency-1) (dresp_valid && !accept));

endmodule

// ==== src/mem_pkg.sv ====
package mem_pkg;

    localparam int xlen        = 32;
    localparam int addr_w      = 10;  // 1 KiB of data RAM
    localparam int iid_w       = 4;
    localparam int ram_latency = 2;
    localparam int ram_words   = 2 ** (addr_w - 2);
    localparam int lat_cnt_w   = $clog2(ram_latency + 1);

    // memory stage states
    localparam logic [1:0] st_idle       = 2'd0;
    localparam logic [1:0] st_wait_ready = 2'd1;
    localparam logic [1:0] st_wait_valid = 2'd2;

    typedef enum logic [1:0] {
        sel_none   = 2'd0,
        sel_load   = 2'd1,
        sel_store  = 2'd2,
        sel_atomic = 2'd3
    } mem_sel_t;

    typedef enum logic [1:0] {
        size_b = 2'd0,
        size_h = 2'd1,
        size_w = 2'd2
    } mem_size_t;

    typedef enum logic [3:0] {
        amo_lr   = 4'd0,
        amo_sc   = 4'd1,
        amo_swap = 4'd2,
        amo_add  = 4'd3,
        amo_xor  = 4'd4,
        amo_and  = 4'd5,
        amo_or   = 4'd6,
        amo_min  = 4'd7,
        amo_max  = 4'd8,
        amo_minu = 4'd9,
        amo_maxu = 4'd10
    } amo_sel_t;

    // op field, meaning depends on mem_sel_t
    typedef union packed {
        struct packed {
            logic      is_signed;
            logic      rsvd;
            mem_size_t size;
        } plain;          // sel_load, sel_store
        amo_sel_t amo;    // sel_atomic
    } mem_op_u;

endpackage

// ==== src/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         mem_valid,
    input  logic [mem_pkg::iid_w-1:0]    mem_inst_id,
    input  mem_pkg::mem_sel_t            mem_sel,
    input  mem_pkg::mem_op_u             mem_op,
    input  logic [mem_pkg::addr_w-1:0]   mem_addr,
    input  logic [mem_pkg::xlen-1:0]     mem_wdata,

    output logic                         wb_valid,
    output logic [mem_pkg::iid_w-1:0]    wb_inst_id,
    output logic [mem_pkg::xlen-1:0]     wb_rdata,
    output logic                         stall
);

    logic                          dreq_valid;
    logic                          dreq_wen;
    logic [mem_pkg::addr_w-1:0]    dreq_addr;
    logic [mem_pkg::xlen-1:0]      dreq_wdata;
    mem_pkg::mem_size_t            dreq_size;
    logic                          dreq_ready;
    logic                          dresp_valid;
    logic [mem_pkg::xlen-1:0]      dresp_rdata;

    memory_stage u_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_valid   (mem_valid),
        .mem_inst_id (mem_inst_id),
        .mem_sel     (mem_sel),
        .mem_op      (mem_op),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .dreq_valid  (dreq_valid),
        .dreq_wen    (dreq_wen),
        .dreq_addr   (dreq_addr),
        .dreq_wdata  (dreq_wdata),
        .dreq_size   (dreq_size),
        .dreq_ready  (dreq_ready),
        .dresp_valid (dresp_valid),
        .dresp_rdata (dresp_rdata),
        .wb_valid    (wb_valid),
        .wb_inst_id  (wb_inst_id),
        .wb_rdata    (wb_rdata),
        .stall       (stall)
    );

    data_ram u_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .dreq_valid  (dreq_valid),
        .dreq_wen    (dreq_wen),
        .dreq_addr   (dreq_addr),
        .dreq_wdata  (dreq_wdata),
        .dreq_size   (dreq_size),
        .dreq_ready  (dreq_ready),
        .dresp_valid (dresp_valid),
        .dresp_rdata (dresp_rdata)
    );

endmodule

// ==== src/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         mem_valid,
    input  logic [mem_pkg::iid_w-1:0]    mem_inst_id,
    input  mem_pkg::mem_sel_t            mem_sel,
    input  mem_pkg::mem_op_u             mem_op,
    input  logic [mem_pkg::addr_w-1:0]   mem_addr,
    input  logic [mem_pkg::xlen-1:0]     mem_wdata,

    output logic                         dreq_valid,
    output logic                         dreq_wen,
    output logic [mem_pkg::addr_w-1:0]   dreq_addr,
    output logic [mem_pkg::xlen-1:0]     dreq_wdata,
    output mem_pkg::mem_size_t           dreq_size,
    input  logic                         dreq_ready,

    input  logic                         dresp_valid,
    input  logic [mem_pkg::xlen-1:0]     dresp_rdata,

    output logic                         wb_valid,
    output logic [mem_pkg::iid_w-1:0]    wb_inst_id,
    output logic [mem_pkg::xlen-1:0]     wb_rdata,
    output logic                         stall
);

    logic [1:0]                    state;
    logic                          executed;
    logic [mem_pkg::iid_w-1:0]     saved_id;
    mem_pkg::mem_sel_t             replace_sel;  // kind of the phase in flight
    mem_pkg::mem_sel_t             cur_sel;
    logic                          may_start;

    logic                          resv_valid;
    logic [mem_pkg::addr_w-1:0]    resv_addr;
    logic                          sc_hit;
    logic                          sc_ok;
    logic                          lr_start;

    logic [mem_pkg::xlen-1:0]      saved_rdata;
    logic [mem_pkg::xlen-1:0]      amo_wdata;

    assign may_start = !executed || saved_id != mem_inst_id;

    always_comb begin
        if (!mem_valid)
            cur_sel = mem_pkg::sel_none;
        else if (replace_sel != mem_pkg::sel_none)
            cur_sel = replace_sel;
        else if (state == mem_pkg::st_idle && may_start)
            cur_sel = mem_sel;
        else
            cur_sel = mem_pkg::sel_none;
    end

    assign sc_hit   = resv_valid && resv_addr == mem_addr;
    assign lr_start = state == mem_pkg::st_idle && cur_sel == mem_pkg::sel_atomic
                      && mem_op.amo == mem_pkg::amo_lr;

    amo_alu u_amo (
        .amo_sel  (mem_op.amo),
        .old_data (saved_rdata),
        .operand  (mem_wdata),
        .new_data (amo_wdata)
    );

    assign dreq_valid = mem_valid && state == mem_pkg::st_wait_ready;
    assign dreq_wen   = replace_sel == mem_pkg::sel_store;
    assign dreq_addr  = mem_addr;
    assign dreq_wdata = mem_sel == mem_pkg::sel_atomic ? amo_wdata : mem_wdata;
    assign dreq_size  = mem_sel == mem_pkg::sel_atomic ? mem_pkg::size_w : mem_op.plain.size;

    assign stall = mem_valid && (state != mem_pkg::st_idle || cur_sel != mem_pkg::sel_none);

    assign wb_valid   = mem_valid;
    assign wb_inst_id = mem_inst_id;

    always_comb begin
        case (mem_sel)
            mem_pkg::sel_load: begin
                case (mem_op.plain.size)
                    mem_pkg::size_b:
                        wb_rdata = mem_op.plain.is_signed ?
                            {{(mem_pkg::xlen-8){saved_rdata[7]}}, saved_rdata[7:0]} :
                            {{(mem_pkg::xlen-8){1'b0}}, saved_rdata[7:0]};
                    mem_pkg::size_h:
                        wb_rdata = mem_op.plain.is_signed ?
                            {{(mem_pkg::xlen-16){saved_rdata[15]}}, saved_rdata[15:0]} :
                            {{(mem_pkg::xlen-16){1'b0}}, saved_rdata[15:0]};
                    default:
                        wb_rdata = saved_rdata;
                endcase
            end
            mem_pkg::sel_atomic: begin
                if (mem_op.amo == mem_pkg::amo_sc)
                    wb_rdata = {{(mem_pkg::xlen-1){1'b0}}, !sc_ok};  // 0 on success
                else
                    wb_rdata = saved_rdata;  // lr and amo give the old word
            end
            default: wb_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= mem_pkg::st_idle;
            executed    <= 1'b0;
            saved_id    <= '0;
            replace_sel <= mem_pkg::sel_none;
            resv_valid  <= 1'b0;
            sc_ok       <= 1'b0;
        end else begin
            if (mem_valid)
                saved_id <= mem_inst_id;

            if (cur_sel == mem_pkg::sel_none) begin
                state       <= mem_pkg::st_idle;
                replace_sel <= mem_pkg::sel_none;
            end else begin
                case (state)
                    mem_pkg::st_idle: begin
                        executed <= 1'b0;
                        state    <= mem_pkg::st_wait_ready;
                        if (cur_sel == mem_pkg::sel_atomic) begin
                            case (mem_op.amo)
                                mem_pkg::amo_lr: begin
                                    replace_sel <= mem_pkg::sel_load;
                                    resv_valid  <= 1'b1;
                                end
                                mem_pkg::amo_sc: begin
                                    resv_valid <= 1'b0;  // any sc drops the reservation
                                    sc_ok      <= sc_hit;
                                    if (sc_hit) begin
                                        replace_sel <= mem_pkg::sel_store;
                                    end else begin
                                        state       <= mem_pkg::st_idle;
                                        replace_sel <= mem_pkg::sel_none;
                                        executed    <= 1'b1;
                                    end
                                end
                                default: replace_sel <= mem_pkg::sel_atomic;
                            endcase
                        end else begin
                            replace_sel <= cur_sel;
                        end
                    end
                    mem_pkg::st_wait_ready: begin
                        if (dreq_ready) begin
                            if (replace_sel == mem_pkg::sel_store) begin
                                state       <= mem_pkg::st_idle;
                                replace_sel <= mem_pkg::sel_none;
                                executed    <= 1'b1;
                            end else begin
                                state <= mem_pkg::st_wait_valid;
                            end
                        end
                    end
                    mem_pkg::st_wait_valid: begin
                        if (dresp_valid) begin
                            state <= mem_pkg::st_idle;
                            if (replace_sel == mem_pkg::sel_atomic) begin
                                replace_sel <= mem_pkg::sel_store;  // write-back phase
                            end else begin
                                replace_sel <= mem_pkg::sel_none;
                                executed    <= 1'b1;
                            end
                        end
                    end
                    default: state <= mem_pkg::st_idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lr_start)
            resv_addr <= mem_addr;
        if (state == mem_pkg::st_wait_valid && dresp_valid)
            saved_rdata <= dresp_rdata;
    end

    // request must hold until the RAM takes it
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dreq_valid && !dreq_ready |=> dreq_valid && $stable(dreq_addr));

    a_resp_expected: assert property (@(posedge clk) disable iff (!rst_n)
        dresp_valid |-> state == mem_pkg::st_wait_valid);

endmodule
